/* build.f */
+incdir+.
cam_lookup_pkg.sv
cam_config_decoder.sv
cam_match_array.sv
lookup_output_ctrl.sv
cam_lookup_stage.sv
tb_clock_gen.sv
tb_checker.sv
tb_cam_lookup.sv

/* Bender.yml */
package:
  name: cam_lookup

export_include_dirs:
  - .

sources:
  - cam_lookup_pkg.sv
  - cam_config_decoder.sv
  - cam_match_array.sv
  - lookup_output_ctrl.sv
  - cam_lookup_stage.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_cam_lookup.sv

/* tb_cam_lookup.sv */
`timescale 1ns/1ps

`include "cam_lookup_settings.svh"

module tb_cam_lookup import cam_lookup_pkg::*; ();

    localparam int         TIMEOUT    = 40;
    localparam logic [7:0] CFG_MOD_ID = {5'(`DEF_STAGE_ID), 3'(`DEF_LOOKUP_ID)};

    logic              clk;
    logic              rst_n;
    lookup_req_t       req;
    bit                ready_out;
    lookup_result_t    res;
    bit                ready_in;
    ctrl_beat_t        ctrl_in;
    ctrl_beat_t        ctrl_out;
    // Entry words for the next table write
    logic [`CAM_W-1:0] words [$];

    tb_clock_gen clkgen (.clk(clk), .rst_n(rst_n));

    cam_lookup_stage dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ready_out(ready_out),
        .res      (res),
        .ready_in (ready_in),
        .ctrl_in  (ctrl_in),
        .ctrl_out (ctrl_out)
    );

    tb_checker chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ready_out(ready_out),
        .res      (res),
        .ready_in (ready_in),
        .ctrl_in  (ctrl_in),
        .ctrl_out (ctrl_out)
    );

    // ========================================
    // Stimulus helpers
    // ========================================
    function automatic logic [127:0] rand128();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic logic [`CTRL_DATA_W-1:0] make_header(input logic [7:0] mod_id,
            input logic [3:0] kind, input logic [15:0] flag, input logic [3:0] index);
        logic [`CTRL_DATA_W-1:0] data;
        data = rand128();
        data[`MOD_ID_LSB +: 8]          = mod_id;
        data[`RESV_LSB +: 4]            = kind;
        data[`FLAG_LSB +: 16]           = flag;
        data[`INDEX_LSB +: `CAM_ADDR_W] = index;
        return data;
    endfunction

    // Word goes byte reversed into the low half
    function automatic logic [`CTRL_DATA_W-1:0] make_entry(input logic [`CAM_W-1:0] word);
        logic [`CTRL_DATA_W-1:0] data;
        data = rand128();
        for (int i = 0; i < `CAM_W / 8; i++) begin
            data[i*8 +: 8] = word[`CAM_W - 8 - i*8 +: 8];
        end
        return data;
    endfunction

    // Key from the low bits and the VLAN nibble rotated back
    function automatic lookup_req_t make_request(input logic [`CAM_W-1:0] word);
        lookup_req_t r;
        r.valid = 1'b1;
        r.key   = word[`KEY_W-1:0];
        r.phv   = rand128();
        r.phv[`VLAN_LSB +: `VLAN_W] = {word[`CAM_W-5 -: 8], word[`CAM_W-1 -: 4]};
        return r;
    endfunction

    task automatic fail_on_timeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_beat(input logic [`CTRL_DATA_W-1:0] data, input logic last);
        ctrl_in = '{valid: 1'b1, last: last, data: data};
        @(posedge clk);
        #1;
        ctrl_in.valid = 1'b0;
    endtask

    task automatic write_table(input logic [3:0] index);
        send_beat(make_header(CFG_MOD_ID, ENTRY_CAM, `CTRL_FLAG, index), words.size() == 0);
        foreach (words[i]) begin
            send_beat(make_entry(words[i]), i == words.size() - 1);
        end
    endtask

    task automatic issue_request(input lookup_req_t r);
        int waited;
        waited = 0;
        req    = r;
        while (!ready_out && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ready_out) begin
            fail_on_timeout("request acceptance");
        end
        @(posedge clk);
        #1;
        req.valid = 1'b0;
    endtask

    task automatic wait_result();
        int waited;
        waited = 0;
        while (!res.valid && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!res.valid) begin
            fail_on_timeout("lookup result");
        end
        wait_cycles(1);
    endtask

    task automatic run_lookup(input lookup_req_t r);
        issue_request(r);
        wait_result();
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        logic [`CAM_W-1:0] word;
        lookup_req_t       r;
        int                waited;
        int                flip_bit;
        req      = '0;
        ready_in = 1'b1;
        ctrl_in  = '0;
        void'($urandom(32'h2438));
        waited = 0;
        while (rst_n !== 1'b1 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            fail_on_timeout("reset release");
        end
        wait_cycles(1);

        run_lookup(make_request({$urandom, $urandom}));
        chk.end_test("empty table");

        word = {$urandom, $urandom};
        words.push_back(word);
        write_table($urandom_range(0, 15));
        wait_cycles(2);
        r = make_request(word);
        run_lookup(r);
        flip_bit = $urandom_range(0, `KEY_W - 1);
        r.key[flip_bit] = ~r.key[flip_bit];
        run_lookup(r);
        chk.end_test("single write");

        // Four entries where the last one repeats the second
        words.delete();
        repeat (3) words.push_back({$urandom, $urandom});
        words.push_back(words[1]);
        write_table($urandom_range(0, 15));
        wait_cycles(2);
        foreach (words[i]) begin
            run_lookup(make_request(words[i]));
        end
        chk.end_test("burst write");

        // Wrong stage, wrong tag and action opcode around one real write
        word = {$urandom, $urandom};
        send_beat(make_header({5'd3, CFG_MOD_ID[2:0]}, ENTRY_CAM, `CTRL_FLAG, 4'd1), 1'b0);
        send_beat(make_entry(word), 1'b1);
        send_beat(make_header(CFG_MOD_ID, ENTRY_CAM, 16'hF2F0, 4'd2), 1'b0);
        send_beat(make_entry(word), 1'b1);
        words.delete();
        words.push_back(~word);
        write_table($urandom_range(0, 15));
        send_beat(make_header(CFG_MOD_ID, ENTRY_ACTION, `CTRL_FLAG, 4'd3), 1'b0);
        send_beat(make_entry(word), 1'b1);
        wait_cycles(3);
        run_lookup(make_request(word));
        run_lookup(make_request(~word));
        chk.end_test("passthrough");

        ready_in = 1'b0;
        issue_request(make_request(words[0]));
        wait_cycles($urandom_range(3, 10));
        ready_in = 1'b1;
        wait_result();
        run_lookup(make_request({$urandom, $urandom}));
        chk.end_test("back-pressure");

        chk.final_report();
        if (chk.errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

`include "cam_lookup_settings.svh"

module tb_checker import cam_lookup_pkg::*; #(
    parameter logic [4:0] stage_id  = `DEF_STAGE_ID,
    parameter logic [2:0] lookup_id = `DEF_LOOKUP_ID
) (
    input logic           clk,
    input logic           rst_n,
    input lookup_req_t    req,
    input bit             ready_out,
    input lookup_result_t res,
    input bit             ready_in,
    input ctrl_beat_t     ctrl_in,
    input ctrl_beat_t     ctrl_out
);

    logic [`CAM_W-1:0]      shadow_entry [`CAM_DEPTH];
    logic [`CAM_DEPTH-1:0]  shadow_valid;
    logic [`CAM_ADDR_W-1:0] shadow_index;
    cfg_state_e             cfg_state;
    logic                   ready_in_q;
    lookup_result_t         pending_res [$];
    ctrl_beat_t             pending_ctrl [$];
    int                     checks      = 0;
    int                     errors      = 0;
    int                     test_checks = 0;
    int                     test_errors = 0;

    // ========================================
    // Reference model
    // ========================================
    function automatic lookup_result_t expected_lookup(input lookup_req_t r);
        lookup_result_t     exp;
        logic [`VLAN_W-1:0] vlan;
        logic [`CAM_W-1:0]  word;
        vlan      = r.phv[`VLAN_LSB +: `VLAN_W];
        word      = {vlan[3:0], vlan[`VLAN_W-1:4], r.key};
        exp       = '0;
        exp.valid = 1'b1;
        exp.addr  = '1;
        exp.phv   = r.phv;
        // Walk down so the lowest matching index is kept
        for (int i = `CAM_DEPTH - 1; i >= 0; i--) begin
            if (shadow_valid[i] && shadow_entry[i] == word) begin
                exp.hit  = 1'b1;
                exp.addr = i;
            end
        end
        return exp;
    endfunction

    // Top bits of the byte-swapped beat
    function automatic logic [`CAM_W-1:0] entry_word(input logic [`CTRL_DATA_W-1:0] data);
        logic [`CTRL_DATA_W-1:0] swapped;
        for (int i = 0; i < `CTRL_DATA_W / 8; i++) begin
            swapped[i*8 +: 8] = data[`CTRL_DATA_W - 8 - i*8 +: 8];
        end
        return swapped[`CTRL_DATA_W-1 -: `CAM_W];
    endfunction

    function automatic logic is_table_header(input logic [`CTRL_DATA_W-1:0] data);
        logic [7:0] mod_id;
        mod_id = data[`MOD_ID_LSB +: 8];
        return (mod_id[7:3] == stage_id) && (mod_id[2:0] == lookup_id)
               && (data[`FLAG_LSB +: 16] == `CTRL_FLAG)
               && (data[`RESV_LSB +: 4] == 4'(ENTRY_CAM));
    endfunction

    // ========================================
    // Reporting
    // ========================================
    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        test_errors++;
        $display("Problem at %0t ns: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic final_report();
        if (pending_res.size() != 0) begin
            report_problem("lookup requests never answered");
        end
        if (pending_ctrl.size() != 0) begin
            report_problem("passthrough beats never seen on ctrl_out");
        end
        $display("Totals: %0d checks, %0d errors", checks, errors);
    endtask

    // ========================================
    // Monitor and compare
    // ========================================
    always @(posedge clk) begin
        lookup_result_t exp_res;
        ctrl_beat_t     exp_beat;
        if (!rst_n) begin
            shadow_valid = '0;
            shadow_index = '0;
            cfg_state    = CFG_IDLE;
            ready_in_q   = 1'b0;
        end else begin
            if (res.valid && !ready_in_q) begin
                report_problem("result delivered while ready_in was low");
            end
            if (res.valid && pending_res.size() == 0) begin
                report_problem("result without a pending request");
            end else if (res.valid) begin
                exp_res = pending_res.pop_front();
                check_value("res.hit", exp_res.hit, res.hit);
                check_value("res.addr", exp_res.addr, res.addr);
                check_value("res.phv", exp_res.phv, res.phv);
            end
            if (ctrl_out.valid && pending_ctrl.size() == 0) begin
                report_problem("unexpected beat on ctrl_out");
            end else if (ctrl_out.valid) begin
                exp_beat = pending_ctrl.pop_front();
                check_value("ctrl_out.data", exp_beat.data, ctrl_out.data);
                check_value("ctrl_out.last", exp_beat.last, ctrl_out.last);
            end
            // One lookup in flight at most
            check_value("ready_out", pending_res.size() == 0, ready_out);
            if (req.valid && ready_out) begin
                pending_res.push_back(expected_lookup(req));
            end
            if (ctrl_in.valid && cfg_state == CFG_ENTRY) begin
                shadow_entry[shadow_index] = entry_word(ctrl_in.data);
                shadow_valid[shadow_index] = 1'b1;
                shadow_index = shadow_index + 1'b1;
                if (ctrl_in.last) begin
                    cfg_state = CFG_IDLE;
                end
            end else if (ctrl_in.valid && is_table_header(ctrl_in.data)) begin
                shadow_index = ctrl_in.data[`INDEX_LSB +: `CAM_ADDR_W];
                if (!ctrl_in.last) begin
                    cfg_state = CFG_ENTRY;
                end
            end else if (ctrl_in.valid) begin
                pending_ctrl.push_back(ctrl_in);
            end
            ready_in_q = ready_in;
        end
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held for five rising edges, released just after the fifth
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

/* cam_lookup_stage.sv */
`timescale 1ns/1ps

`include "cam_lookup_settings.svh"

module cam_lookup_stage import cam_lookup_pkg::*; #(
    parameter logic [4:0] stage_id  = `DEF_STAGE_ID,
    parameter logic [2:0] lookup_id = `DEF_LOOKUP_ID
) (
    input  logic           clk,
    input  logic           rst_n,

    // Data path
    input  lookup_req_t    req,
    output bit             ready_out,
    output lookup_result_t res,
    input  bit             ready_in,

    // Control path
    input  ctrl_beat_t     ctrl_in,
    output ctrl_beat_t     ctrl_out
);

    cam_write_t             cam_wr;
    bit                     search;
    logic [`CAM_W-1:0]      cmp_word;
    bit                     hit;
    logic [`CAM_ADDR_W-1:0] match_addr;

    // ========================================
    // Table programming
    // ========================================
    cam_config_decoder #(
        .stage_id  (stage_id),
        .lookup_id (lookup_id)
    ) u_cfg_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl_in  (ctrl_in),
        .ctrl_out (ctrl_out),
        .cam_wr   (cam_wr)
    );

    // ========================================
    // Match table and lookup control
    // ========================================
    cam_match_array u_match_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .cam_wr     (cam_wr),
        .search     (search),
        .cmp_word   (cmp_word),
        .hit        (hit),
        .match_addr (match_addr)
    );

    lookup_output_ctrl u_output_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .ready_out  (ready_out),
        .search     (search),
        .cmp_word   (cmp_word),
        .hit        (hit),
        .match_addr (match_addr),
        .ready_in   (ready_in),
        .res        (res)
    );

endmodule

/* lookup_output_ctrl.sv */
`timescale 1ns/1ps

`include "cam_lookup_settings.svh"

module lookup_output_ctrl import cam_lookup_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lookup_req_t            req,
    output bit                     ready_out,
    output bit                     search,
    output logic [`CAM_W-1:0]      cmp_word,
    input  bit                     hit,
    input  logic [`CAM_ADDR_W-1:0] match_addr,
    input  bit                     ready_in,
    output lookup_result_t         res
);

    lookup_state_e state;

    logic [`VLAN_W-1:0]     vlan_id;
    logic                   accept;
    logic                   search_q;
    logic [`CAM_W-1:0]      cmp_q;
    logic [`PHV_W-1:0]      phv_q;
    logic                   res_valid;
    logic                   res_hit;
    logic [`CAM_ADDR_W-1:0] res_addr;

    assign vlan_id   = req.phv[`VLAN_LSB +: `VLAN_W];
    assign ready_out = (state == LK_IDLE);
    assign accept    = req.valid && ready_out;

    // ========================================
    // Lookup FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= LK_IDLE;
            search_q  <= 1'b0;
            res_valid <= 1'b0;
            res_hit   <= 1'b0;
            res_addr  <= '0;
        end else begin
            search_q  <= accept;
            res_valid <= 1'b0;
            case (state)
                LK_IDLE: begin
                    if (accept) begin
                        state <= LK_WAIT;
                    end
                end
                // First WAIT cycle is spent in the table search
                LK_WAIT, LK_HALT: begin
                    if (!search_q && ready_in) begin
                        res_valid <= 1'b1;
                        res_hit   <= hit;
                        res_addr  <= hit ? match_addr : {`CAM_ADDR_W{1'b1}};
                        state     <= LK_IDLE;
                    end else if (!search_q) begin
                        state <= LK_HALT;
                    end
                end
                default: state <= LK_IDLE;
            endcase
        end
    end

    // Low VLAN nibble goes above the upper byte
    always_ff @(posedge clk) begin
        if (accept) begin
            cmp_q <= {vlan_id[3:0], vlan_id[`VLAN_W-1:4], req.key};
            phv_q <= req.phv;
        end
    end

    assign search   = search_q;
    assign cmp_word = cmp_q;
    assign res      = '{valid: res_valid, hit: res_hit, addr: res_addr, phv: phv_q};

    assert property (@(posedge clk) disable iff (!rst_n) res.valid |-> ready_in)
        else $error("result delivered without downstream ready");

endmodule

/* cam_match_array.sv */
`timescale 1ns/1ps

`include "cam_lookup_settings.svh"

module cam_match_array import cam_lookup_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cam_write_t             cam_wr,
    input  bit                     search,
    input  logic [`CAM_W-1:0]      cmp_word,
    output bit                     hit,
    output logic [`CAM_ADDR_W-1:0] match_addr
);

    logic [`CAM_W-1:0]     entries [`CAM_DEPTH];
    logic [`CAM_DEPTH-1:0] entry_valid;

    logic [`CAM_DEPTH-1:0]  match_vec;
    logic                   any_match;
    logic [`CAM_ADDR_W-1:0] first_idx;

    // ========================================
    // Table storage
    // ========================================
    always_ff @(posedge clk) begin
        if (cam_wr.en) begin
            entries[cam_wr.addr] <= cam_wr.entry;
        end
    end

    // Unwritten entries must never match
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (cam_wr.en) begin
            entry_valid[cam_wr.addr] <= 1'b1;
        end
    end

    // ========================================
    // Compare and priority encode
    // ========================================
    always_comb begin
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            match_vec[i] = entry_valid[i] && (entries[i] == cmp_word);
        end
    end

    assign any_match = |match_vec;

    // Scan downwards so the lowest index wins
    always_comb begin
        first_idx = '0;
        for (int i = `CAM_DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                first_idx = i[`CAM_ADDR_W-1:0];
            end
        end
    end

    // Result holds until the next search
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit        <= 1'b0;
            match_addr <= '0;
        end else if (search) begin
            hit        <= any_match;
            match_addr <= first_idx;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) cam_wr.en |-> cam_wr.addr < `CAM_DEPTH)
        else $error("table write address out of range");

endmodule

/* cam_config_decoder.sv */
`timescale 1ns/1ps

`include "cam_lookup_settings.svh"

module cam_config_decoder import cam_lookup_pkg::*; #(
    parameter logic [4:0] stage_id  = `DEF_STAGE_ID,
    parameter logic [2:0] lookup_id = `DEF_LOOKUP_ID
) (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_beat_t ctrl_in,
    output ctrl_beat_t ctrl_out,
    output cam_write_t cam_wr
);

    localparam int NUM_BYTES = `CTRL_DATA_W / 8;

    cfg_state_e state;

    logic [7:0]              mod_id;
    logic [3:0]              resv;
    logic [15:0]             ctrl_flag;
    logic                    is_cam_hdr;
    logic [`CTRL_DATA_W-1:0] data_swapped;

    // Address for the next entry beat
    logic [`CAM_ADDR_W-1:0] next_index;

    logic                    out_valid;
    logic                    out_last;
    logic [`CTRL_DATA_W-1:0] out_data;
    logic                    wr_en;
    logic [`CAM_ADDR_W-1:0]  wr_addr;
    logic [`CAM_W-1:0]       wr_entry;

    // ========================================
    // Header decode
    // ========================================
    assign mod_id    = ctrl_in.data[`MOD_ID_LSB +: 8];
    assign resv      = ctrl_in.data[`RESV_LSB +: 4];
    assign ctrl_flag = ctrl_in.data[`FLAG_LSB +: 16];

    assign is_cam_hdr = (mod_id[7:3] == stage_id) && (mod_id[2:0] == lookup_id)
                        && (ctrl_flag == `CTRL_FLAG)
                        && (entry_kind_e'(resv) == ENTRY_CAM);

    // Entry beats arrive little endian
    for (genvar i = 0; i < NUM_BYTES; i++) begin : g_swap
        assign data_swapped[i*8 +: 8] = ctrl_in.data[(NUM_BYTES-1-i)*8 +: 8];
    end

    // ========================================
    // Control stream FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= CFG_IDLE;
            next_index <= '0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            wr_en      <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            wr_en     <= 1'b0;
            case (state)
                CFG_IDLE: begin
                    if (ctrl_in.valid && is_cam_hdr) begin
                        next_index <= ctrl_in.data[`INDEX_LSB +: `CAM_ADDR_W];
                        // A header without entries ends right here
                        if (!ctrl_in.last) begin
                            state <= CFG_ENTRY;
                        end
                    end else if (ctrl_in.valid) begin
                        out_valid <= 1'b1;
                        out_last  <= ctrl_in.last;
                    end
                end
                CFG_ENTRY: begin
                    if (ctrl_in.valid) begin
                        wr_en      <= 1'b1;
                        next_index <= next_index + 1'b1;
                        if (ctrl_in.last) begin
                            state <= CFG_IDLE;
                        end
                    end
                end
                default: state <= CFG_IDLE;
            endcase
        end
    end

    // Payload follows the control bits above
    always_ff @(posedge clk) begin
        out_data <= ctrl_in.data;
        wr_addr  <= next_index;
        wr_entry <= data_swapped[`CTRL_DATA_W-1 -: `CAM_W];
    end

    assign ctrl_out = '{valid: out_valid, last: out_last, data: out_data};
    assign cam_wr   = '{en: wr_en, addr: wr_addr, entry: wr_entry};

    // Table programming beats are consumed, never forwarded
    assert property (@(posedge clk) disable iff (!rst_n) !(cam_wr.en && ctrl_out.valid))
        else $error("table write and passthrough beat in the same cycle");

endmodule

/* cam_lookup_pkg.sv */
`include "cam_lookup_settings.svh"

package cam_lookup_pkg;

    // ========================================
    // Stream and table records
    // ========================================

    // One beat of the control stream, no back-pressure
    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic [`CTRL_DATA_W-1:0] data;
    } ctrl_beat_t;

    // Single entry write into the match table
    typedef struct packed {
        logic                   en;
        logic [`CAM_ADDR_W-1:0] addr;
        logic [`CAM_W-1:0]      entry;
    } cam_write_t;

    typedef struct packed {
        logic              valid;
        logic [`KEY_W-1:0] key;
        logic [`PHV_W-1:0] phv;
    } lookup_req_t;

    // Stage output, addr is all ones on a miss
    typedef struct packed {
        logic                   valid;
        logic                   hit;
        logic [`CAM_ADDR_W-1:0] addr;
        logic [`PHV_W-1:0]      phv;
    } lookup_result_t;

    // ========================================
    // State machines and opcodes
    // ========================================
    typedef enum logic [1:0] {
        LK_IDLE,
        LK_WAIT,
        LK_HALT
    } lookup_state_e;

    typedef enum logic {
        CFG_IDLE,
        CFG_ENTRY
    } cfg_state_e;

    // Header resv field, selects the target table
    typedef enum logic [3:0] {
        ENTRY_CAM    = 4'd0,
        ENTRY_ACTION = 4'd2
    } entry_kind_e;

endpackage

/* cam_lookup_settings.svh */
`ifndef CAM_LOOKUP_SETTINGS_SVH
`define CAM_LOOKUP_SETTINGS_SVH

// ========================================
// Bus and field widths
// ========================================
`define CTRL_DATA_W    128
`define PHV_W          128
`define KEY_W          52
`define VLAN_W         12
// VLAN ID location inside the PHV
`define VLAN_LSB       100
// Reordered VLAN stacked on top of the key
`define CAM_W          64
`define CAM_DEPTH      16
`define CAM_ADDR_W     4

// ========================================
// Control header layout
// ========================================
`define MOD_ID_LSB     112
`define RESV_LSB       120
`define FLAG_LSB       64
`define INDEX_LSB      104
// UDP destination port value tagging table programming
`define CTRL_FLAG      16'hF2F1

// Default stage position in the pipeline
`define DEF_STAGE_ID   0
`define DEF_LOOKUP_ID  2

`endif
